//--- build.f
+incdir+source
source/board_pkg.sv
source/pad_ring.sv
source/jtag_overlay_mux.sv
source/reset_gen.sv
source/jtag_tap.sv
source/gpio_core.sv
source/board_top.sv
tb/board_assertions.sv
tb/board_tb.sv

//--- Makefile
# Verilator build and run of the board wrapper testbench

VERILATOR ?= verilator
TOP       ?= board_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/board_tb.sv
/* Testbench for board_top. Bit-bangs JTAG on the dedicated pads, writes and reads
   the GPIO and AUX registers, and checks the pads against a reference model. */
`timescale 1ns/1ps
`default_nettype none
`include "board_defines.svh"

module board_tb
  import board_pkg::*;
();

  localparam int timeout_cycles = 20000;   // ~6 sequences x 60 TCK x 16 clk, plus margin
  localparam int tck_half       = 8;       // clk cycles per TCK level
  localparam int tck_bit        = `IDX_TCK - `NUM_MIO;
  localparam int tms_bit        = `IDX_TMS - `NUM_MIO;
  localparam int tdi_bit        = `IDX_TDI - `NUM_MIO;
  localparam int tdo_bit        = `IDX_TDO - `NUM_MIO;
  localparam int trst_bit       = `IDX_TRST - `NUM_MIO;

  logic        clk;
  logic        reset;
  mio_vec_t    mio_in, mio_out, mio_oe;
  dio_vec_t    dio_in, dio_out, dio_oe;

  // Model of the register state as written over JTAG
  gpio_word_t  m_gout, m_goe, m_attr;
  led_word_t   m_led;
  logic        m_strap;
  logic [31:0] rng_state;

  // Request from stimulus to the pad comparer
  int          check_seq = 0;
  int          check_done = 0;
  logic [27:0] pad_exp;
  logic [27:0] pad_mask;
  string       check_label;

  int          cycle_count = 0;
  int          pad_errors = 0;
  int          pad_checks = 0;
  int          data_errors, data_checks;
  int          test_num, errors_at_start;

  board_top u_board_top (
    .clk_i     (clk),
    .reset_i   (reset),
    .mio_in_i  (mio_in),
    .mio_out_o (mio_out),
    .mio_oe_o  (mio_oe),
    .dio_in_i  (dio_in),
    .dio_out_o (dio_out),
    .dio_oe_o  (dio_oe)
  );

  always #2 clk = ~clk;   // 4 ns period

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Run stopped after %0d cycles, a JTAG sequence did not finish", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Packed as {dio_oe, dio_out, mio_oe, mio_out}
  function automatic logic [27:0] ref_pads(input logic strap, input gpio_word_t gout,
                                           input gpio_word_t goe, input led_word_t led,
                                           input gpio_word_t attr);
    logic [7:0] m_out, m_oe;
    logic [5:0] d_out, d_oe;
    if (strap) begin
      m_out = {1'b0, gout[6:0]} ^ attr;   // SRST pad owned by debug
      m_oe  = {1'b0, goe[6:0]};
      d_out = 6'b000000;                  // TDO bit masked by the caller
      d_oe  = 6'b001000;                  // Only TDO driven
    end else begin
      m_out = gout ^ attr;
      m_oe  = goe;
      d_out = {2'b00, led};
      d_oe  = 6'b001111;                  // LED always enabled
    end
    return {d_oe, d_out, m_oe, m_out};
  endfunction

  // GPIO capture under debug: oe high, inverted pad inputs low, SRST seen as 0
  function automatic logic [15:0] ref_readback(input mio_vec_t pads, input gpio_word_t attr,
                                               input gpio_word_t goe);
    return {goe, (pads ^ attr) & 8'h7F};
  endfunction

  //////////////////////////////////////////////////
  // Pad comparer
  //////////////////////////////////////////////////

  always @(negedge clk) begin : pad_compare
    logic [27:0] seen;
    seen = {dio_oe, dio_out, mio_oe, mio_out};
    if (check_done != check_seq) begin
      if ((seen & pad_mask) !== (pad_exp & pad_mask)) begin
        $display("MISMATCH @ %0d ns: %s, pads %h expected %h", $time, check_label,
                 seen & pad_mask, pad_exp & pad_mask);
        pad_errors++;
      end
      pad_checks++;
      check_done = check_seq;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  task automatic compare_pads(input string label);
    pad_exp  = ref_pads(m_strap, m_gout, m_goe, m_led, m_attr);
    pad_mask = 28'hFFF_FFFF;
    if (m_strap) pad_mask[16 + tdo_bit] = 1'b0;   // TDO data not modelled
    check_label = label;
    check_seq++;
    wait (check_done == check_seq);
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input string label, input logic [31:0] got,
                            input logic [31:0] exp);
    data_checks++;
    if (got !== exp) begin
      $display("MISMATCH @ %0d ns: %s read %h, expected %h", $time, label, got, exp);
      data_errors++;
    end
  endtask

  // TMS and TDI set with TCK low, TDO sampled just before the rise
  task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
    dio_in[tck_bit] = 1'b0;
    dio_in[tms_bit] = tms;
    dio_in[tdi_bit] = tdi;
    repeat (tck_half) @(posedge clk);
    #1;
    tdo = dio_out[tdo_bit];
    dio_in[tck_bit] = 1'b1;
    repeat (tck_half) @(posedge clk);
    #1;
  endtask

  task automatic tap_to_idle();
    logic tdo;
    repeat (5) tck_cycle(1'b1, 1'b0, tdo);   // Test-Logic-Reset from anywhere
    tck_cycle(1'b0, 1'b0, tdo);              // Run-Test/Idle
  endtask

  task automatic ir_scan(input ir_t ir);
    logic tdo;
    tck_cycle(1'b1, 1'b0, tdo);    // Select-DR
    tck_cycle(1'b1, 1'b0, tdo);    // Select-IR
    tck_cycle(1'b0, 1'b0, tdo);    // Capture-IR
    tck_cycle(1'b0, 1'b0, tdo);    // Shift-IR
    tck_cycle(1'b0, ir[0], tdo);
    tck_cycle(1'b1, ir[1], tdo);   // Exit1-IR
    tck_cycle(1'b1, 1'b0, tdo);    // Update-IR
    tck_cycle(1'b0, 1'b0, tdo);    // Idle, instruction loads here
  endtask

  // LSB first; the final rise leaves Update-DR and the task then holds 8 cycles
  task automatic dr_scan(input int len, input logic [31:0] din, output logic [31:0] dout);
    logic tdo;
    int   i;
    dout = '0;
    tck_cycle(1'b1, 1'b0, tdo);    // Select-DR
    tck_cycle(1'b0, 1'b0, tdo);    // Capture-DR
    tck_cycle(1'b0, 1'b0, tdo);    // Shift-DR, capture loaded
    for (i = 0; i < len; i++) begin
      tck_cycle(i == len - 1, din[i], tdo);
      dout[i] = tdo;
    end
    tck_cycle(1'b1, 1'b0, tdo);    // Update-DR
    tck_cycle(1'b0, 1'b0, tdo);    // Idle, update pulse
  endtask

  task automatic set_strap(input logic on);
    mio_in[`IDX_JTAG_EN] = on;
    m_strap = on;
    repeat (4) @(posedge clk);     // TRST and TCK synchronizers settle
    #1;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = pad_errors + data_errors - errors_at_start;
    test_num++;
    if (errs == 0) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, name, errs);
    end
    errors_at_start = pad_errors + data_errors;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] rd;
    logic [15:0] wr;
    clk    = 1'b0;
    reset  = 1'b1;
    mio_in = 8'h80;                // SRST_n high, strap low
    dio_in = '0;
    dio_in[tms_bit]  = 1'b1;
    dio_in[trst_bit] = 1'b1;       // TRST_n released
    m_gout = '0;
    m_goe  = '0;
    m_led  = 4'b1010;
    m_attr = '0;
    m_strap = 1'b0;
    rng_state = 32'hb06c;
    data_errors = 0;
    data_checks = 0;
    test_num = 0;
    errors_at_start = 0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (`RST_STRETCH + 2) @(posedge clk);   // Core reset stretch
    #1;

    compare_pads("reset defaults");
    end_test("reset defaults");

    set_strap(1'b1);
    tap_to_idle();
    compare_pads("debug owns JTAG pads");
    ir_scan(IR_IDCODE);
    dr_scan(32, 32'h0, rd);
    check_word("IDCODE", rd, `JTAG_IDCODE);
    end_test("IDCODE read");

    ir_scan(IR_GPIO);
    repeat (3) begin
      rng_state = xorshift32(rng_state);
      wr = rng_state[15:0];
      mio_in[5:0] = rng_state[21:16];
      dr_scan(16, {16'h0, wr}, rd);     // Captures the previous state
      check_word("GPIO capture", rd, {16'h0, ref_readback(mio_in, m_attr, m_goe)});
      m_goe  = wr[15:8];
      m_gout = wr[7:0];
      compare_pads("GPIO write");
    end
    dr_scan(16, {16'h0, m_goe, m_gout}, rd);
    check_word("GPIO capture", rd, {16'h0, ref_readback(mio_in, m_attr, m_goe)});
    end_test("GPIO random writes");

    rng_state = xorshift32(rng_state);
    // Strap and SRST keep their polarity, LED differs from the current value
    wr = {4'h0, rng_state[11:9], ~m_led[0], (rng_state[7:0] & 8'h3F) | 8'h01};
    ir_scan(IR_AUX);
    dr_scan(12, {20'h0, wr[11:0]}, rd);
    check_word("AUX capture", rd, {20'h0, m_led, m_attr});
    m_led  = wr[11:8];
    m_attr = wr[7:0];
    compare_pads("inverted outputs, LED hidden");
    ir_scan(IR_GPIO);
    dr_scan(16, {16'h0, m_goe, m_gout}, rd);
    check_word("inverted inputs", rd, {16'h0, ref_readback(mio_in, m_attr, m_goe)});
    set_strap(1'b0);
    compare_pads("LED visible");
    end_test("inversion and LED");

    set_strap(1'b1);
    tap_to_idle();
    ir_scan(IR_GPIO);
    tap_to_idle();                      // Five TMS-high rises
    dr_scan(32, 32'h0, rd);
    check_word("IDCODE after TAP reset", rd, `JTAG_IDCODE);
    end_test("TMS reset");

    ir_scan(IR_GPIO);
    rng_state = xorshift32(rng_state);
    wr = rng_state[15:0] | 16'h0101;    // Some oe and out set
    dr_scan(16, {16'h0, wr}, rd);
    m_goe  = wr[15:8];
    m_gout = wr[7:0];
    compare_pads("GPIO before SRST");
    mio_in[`IDX_SRST] = 1'b0;           // Short SRST_n pulse
    repeat (3) @(posedge clk);
    #1;
    mio_in[`IDX_SRST] = 1'b1;
    repeat (`RST_STRETCH + 4) @(posedge clk);   // Synchronizer plus stretch
    #1;
    m_gout = '0;
    m_goe  = '0;
    m_led  = 4'b1010;
    m_attr = '0;
    compare_pads("GPIO after SRST");
    dr_scan(16, 32'h0, rd);             // No IR scan, GPIO still selected
    check_word("GPIO capture after SRST", rd, {16'h0, ref_readback(mio_in, m_attr, m_goe)});
    end_test("system reset");

    $display("checks: %0d pad, %0d data; errors: %0d", pad_checks, data_checks,
             pad_errors + data_errors);
    if (pad_errors + data_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/board_assertions.sv
/* Concurrent checks bound into board_top: the unbonded pad never drives, JTAG pad
   directions follow the strap, and GPIO enables stay off during core reset. */
`timescale 1ns/1ps
`default_nettype none
`include "board_defines.svh"

module board_assertions
  import board_pkg::*;
(
  input logic       clk_i,
  input logic       reset_i,
  input logic       jtag_en_i,      // Strap as the overlay sees it
  input dio_vec_t   dio_oe_i,
  input logic       core_reset_i,
  input gpio_word_t gpio_oe_i
);

  localparam int tck_bit  = `IDX_TCK - `NUM_MIO;
  localparam int tms_bit  = `IDX_TMS - `NUM_MIO;
  localparam int tdi_bit  = `IDX_TDI - `NUM_MIO;
  localparam int tdo_bit  = `IDX_TDO - `NUM_MIO;
  localparam int trst_bit = `IDX_TRST - `NUM_MIO;

  // DIO 5 not bonded
  dio5_never_driven: assert property (@(posedge clk_i) disable iff (reset_i)
    !dio_oe_i[`NUM_DIO-1])
    else $error("DIO 5 output enable set on an unbonded pad");

  // Debug inputs released, TDO driven
  jtag_pad_dir: assert property (@(posedge clk_i) disable iff (reset_i)
    jtag_en_i |-> (!dio_oe_i[tck_bit] && !dio_oe_i[tms_bit] && !dio_oe_i[tdi_bit] &&
                   !dio_oe_i[trst_bit] && dio_oe_i[tdo_bit]))
    else $error("JTAG pad direction wrong while the strap is set");

  // Register clears one edge after core reset is seen
  gpio_oe_off_in_reset: assert property (@(posedge clk_i) disable iff (reset_i)
    core_reset_i |=> (gpio_oe_i == '0))
    else $error("GPIO output enable active during core reset");

endmodule

bind board_top board_assertions u_board_assertions (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .jtag_en_i    (in_padring[`IDX_JTAG_EN]),
  .dio_oe_i     (dio_oe_o),
  .core_reset_i (core_reset),
  .gpio_oe_i    (gpio_oe)
);

`default_nettype wire

//--- source/board_top.sv
/* Board top level. Pads connect through the pad ring and the JTAG overlay to a
   small core of debug TAP and GPIO registers; a single clk_i runs everything. */
`timescale 1ns/1ps
`default_nettype none
`include "board_defines.svh"

module board_top
  import board_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  // Muxed pads
  input  mio_vec_t mio_in_i,
  output mio_vec_t mio_out_o,
  output mio_vec_t mio_oe_o,
  // Dedicated pads
  input  dio_vec_t dio_in_i,
  output dio_vec_t dio_out_o,
  output dio_vec_t dio_oe_o
);

  io_vec_t     in_padring, out_padring, oe_padring;
  io_vec_t     in_core, out_core, oe_core;
  gpio_word_t  mio_attr;
  gpio_word_t  gpio_out, gpio_oe;
  led_word_t   led;
  logic        jtag_tck, jtag_tms, jtag_tdi, jtag_tdo;
  logic        jtag_trst_n, jtag_srst_n;
  logic        core_reset;
  logic        tap_update;
  ir_t         tap_ir;
  logic [15:0] tap_dr;
  logic [15:0] gpio_capture;
  logic [11:0] aux_capture;

  //////////////////////////////////////////////////
  // Pad ring and JTAG overlay
  //////////////////////////////////////////////////

  pad_ring u_pad_ring (
    .mio_in_i   (mio_in_i),
    .mio_out_o  (mio_out_o),
    .mio_oe_o   (mio_oe_o),
    .dio_in_i   (dio_in_i),
    .dio_out_o  (dio_out_o),
    .dio_oe_o   (dio_oe_o),
    .core_in_o  (in_padring),
    .core_out_i (out_padring),
    .core_oe_i  (oe_padring),
    .mio_attr_i (mio_attr)
  );

  jtag_overlay_mux u_jtag_mux (
    .in_padring_i  (in_padring),
    .out_padring_o (out_padring),
    .oe_padring_o  (oe_padring),
    .in_core_o     (in_core),
    .out_core_i    (out_core),
    .oe_core_i     (oe_core),
    .jtag_tck_o    (jtag_tck),
    .jtag_tms_o    (jtag_tms),
    .jtag_tdi_o    (jtag_tdi),
    .jtag_trst_n_o (jtag_trst_n),
    .jtag_srst_n_o (jtag_srst_n),
    .jtag_tdo_i    (jtag_tdo)
  );

  //////////////////////////////////////////////////
  // Core
  //////////////////////////////////////////////////

  // GPIO on MIO 0..7, LED on DIO 0..3 always enabled, DIO 4..5 idle
  assign out_core = {2'b00, led, gpio_out};
  assign oe_core  = {2'b00, 4'hF, gpio_oe};

  reset_gen u_reset_gen (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .srst_n_i     (jtag_srst_n),
    .core_reset_o (core_reset)
  );

  jtag_tap u_jtag_tap (
    .clk_i          (clk_i),
    .reset_i        (reset_i),          // Not the core reset, keeps IR on SRST
    .tck_i          (jtag_tck),
    .tms_i          (jtag_tms),
    .tdi_i          (jtag_tdi),
    .trst_n_i       (jtag_trst_n),
    .tdo_o          (jtag_tdo),
    .capture_o      (),
    .update_o       (tap_update),
    .ir_o           (tap_ir),
    .dr_o           (tap_dr),
    .gpio_capture_i (gpio_capture),
    .aux_capture_i  (aux_capture)
  );

  gpio_core u_gpio_core (
    .clk_i          (clk_i),
    .reset_i        (core_reset),
    .update_i       (tap_update),
    .ir_i           (tap_ir),
    .dr_i           (tap_dr),
    .pad_in_i       (in_core[`NUM_MIO-1:0]),
    .gpio_out_o     (gpio_out),
    .gpio_oe_o      (gpio_oe),
    .led_o          (led),
    .mio_attr_o     (mio_attr),
    .gpio_capture_o (gpio_capture),
    .aux_capture_o  (aux_capture)
  );

endmodule

`default_nettype wire

//--- source/gpio_core.sv
/* GPIO, LED and pad attribute registers. Loaded from the TAP data register on
   an update pulse, and supplying the readback words for Capture-DR. */
`timescale 1ns/1ps
`default_nettype none

module gpio_core
  import board_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,          // Stretched core reset
  input  logic        update_i,         // One cycle from the TAP
  input  ir_t         ir_i,
  input  logic [15:0] dr_i,
  input  gpio_word_t  pad_in_i,         // MIO inputs after ring and mux
  output gpio_word_t  gpio_out_o,
  output gpio_word_t  gpio_oe_o,
  output led_word_t   led_o,
  output gpio_word_t  mio_attr_o,
  output logic [15:0] gpio_capture_o,
  output logic [11:0] aux_capture_o
);

  gpio_word_t gpio_out_q;
  gpio_word_t gpio_oe_q;
  led_word_t  led_q;
  gpio_word_t attr_q;   // Per-MIO inversion

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      led_q      <= 4'b1010;   // Visible pattern out of reset
      attr_q     <= '0;
    end else if (update_i) begin
      unique case (ir_code_t'(ir_i))
        IR_GPIO: begin
          gpio_oe_q  <= dr_i[15:8];   // oe in high byte
          gpio_out_q <= dr_i[7:0];
        end
        IR_AUX: begin
          led_q  <= dr_i[11:8];
          attr_q <= dr_i[7:0];
        end
        default: ;   // IDCODE and bypass write nothing
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Outputs and readback
  //////////////////////////////////////////////////

  assign gpio_out_o     = gpio_out_q;
  assign gpio_oe_o      = gpio_oe_q;
  assign led_o          = led_q;
  assign mio_attr_o     = attr_q;
  assign gpio_capture_o = {gpio_oe_q, pad_in_i};   // Live pad inputs
  assign aux_capture_o  = {led_q, attr_q};

endmodule

`default_nettype wire

//--- source/jtag_tap.sv
/* Debug TAP oversampled in the clk_i domain. Pins pass a two-flop synchronizer,
   TCK edges are detected, and capture and update pulse for one clk_i cycle. */
`timescale 1ns/1ps
`default_nettype none
`include "board_defines.svh"

module jtag_tap
  import board_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        tck_i,
  input  logic        tms_i,
  input  logic        tdi_i,
  input  logic        trst_n_i,
  output logic        tdo_o,
  output logic        capture_o,       // Capture-DR left
  output logic        update_o,        // Update-DR left, dr_o valid
  output ir_t         ir_o,
  output logic [15:0] dr_o,
  input  logic [15:0] gpio_capture_i,
  input  logic [11:0] aux_capture_i
);

  logic [1:0]  tck_sync_q, tms_sync_q, tdi_sync_q, trst_sync_q;
  logic        tck_prev_q;
  logic        tck_rise, tck_fall;
  logic        tms, tdi;
  tap_state_t  state_q, state_d;
  ir_code_t    ir_q;           // Active instruction
  ir_t         ir_sr_q;        // IR shift stage
  logic [31:0] dr_q;           // DR shift register, longest chain is IDCODE
  logic [31:0] capture_word;
  logic        tdo_q;
  logic        capture_q, update_q;

  //////////////////////////////////////////////////
  // Pin synchronizers and edge detect
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tck_sync_q  <= '0;
      tms_sync_q  <= '1;
      tdi_sync_q  <= '0;
      trst_sync_q <= '0;
      tck_prev_q  <= 1'b0;
    end else begin
      tck_sync_q  <= {tck_sync_q[0], tck_i};
      tms_sync_q  <= {tms_sync_q[0], tms_i};
      tdi_sync_q  <= {tdi_sync_q[0], tdi_i};
      trst_sync_q <= {trst_sync_q[0], trst_n_i};
      tck_prev_q  <= tck_sync_q[1];
    end
  end

  assign tck_rise = tck_sync_q[1] & ~tck_prev_q;
  assign tck_fall = ~tck_sync_q[1] & tck_prev_q;
  assign tms      = tms_sync_q[1];   // Aligned with synced TCK
  assign tdi      = tdi_sync_q[1];

  //////////////////////////////////////////////////
  // TAP state machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      TEST_LOGIC_RESET: state_d = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_d = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_DR_SCAN:   state_d = tms ? SELECT_IR_SCAN : CAPTURE_DR;
      CAPTURE_DR:       state_d = tms ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR:         state_d = tms ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR:         state_d = tms ? UPDATE_DR : PAUSE_DR;
      PAUSE_DR:         state_d = tms ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR:         state_d = tms ? UPDATE_DR : SHIFT_DR;
      UPDATE_DR:        state_d = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_IR_SCAN:   state_d = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_d = tms ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR:         state_d = tms ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR:         state_d = tms ? UPDATE_IR : PAUSE_IR;
      PAUSE_IR:         state_d = tms ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR:         state_d = tms ? UPDATE_IR : SHIFT_IR;
      UPDATE_IR:        state_d = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
    endcase
  end

  // TRST or board reset forces Test-Logic-Reset
  always_ff @(posedge clk_i) begin
    if (reset_i || !trst_sync_q[1]) begin
      state_q   <= TEST_LOGIC_RESET;
      ir_q      <= IR_IDCODE;
      capture_q <= 1'b0;
      update_q  <= 1'b0;
      tdo_q     <= 1'b0;
    end else begin
      capture_q <= tck_rise && (state_q == CAPTURE_DR);
      update_q  <= tck_rise && (state_q == UPDATE_DR);
      if (tck_rise) begin
        state_q <= state_d;
        if (state_q == UPDATE_IR) ir_q <= ir_code_t'(ir_sr_q);
      end
      if (state_q == TEST_LOGIC_RESET) ir_q <= IR_IDCODE;
      // TDO moves on the falling edge
      if (tck_fall) begin
        if (state_q == SHIFT_IR) begin
          tdo_q <= ir_sr_q[0];
        end else if (state_q == SHIFT_DR) begin
          tdo_q <= dr_q[0];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Shift registers
  //////////////////////////////////////////////////

  always_comb begin
    unique case (ir_q)
      IR_IDCODE: capture_word = `JTAG_IDCODE;
      IR_GPIO:   capture_word = {16'h0, gpio_capture_i};
      IR_AUX:    capture_word = {20'h0, aux_capture_i};
      default:   capture_word = 32'h0;   // Bypass captures 0
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      unique case (state_q)
        CAPTURE_IR: ir_sr_q <= ir_t'(1);   // Fixed 01 pattern
        SHIFT_IR:   ir_sr_q <= {tdi, ir_sr_q[`IR_WIDTH-1:1]};
        CAPTURE_DR: dr_q    <= capture_word;
        SHIFT_DR: begin
          // TDI enters at the top of the selected chain
          unique case (ir_q)
            IR_IDCODE: dr_q <= {tdi, dr_q[31:1]};
            IR_GPIO:   dr_q <= {16'h0, tdi, dr_q[15:1]};
            IR_AUX:    dr_q <= {20'h0, tdi, dr_q[11:1]};
            default:   dr_q <= {31'h0, tdi};
          endcase
        end
        default: ;
      endcase
    end
  end

  assign tdo_o     = tdo_q;
  assign capture_o = capture_q;
  assign update_o  = update_q;
  assign ir_o      = ir_t'(ir_q);
  assign dr_o      = dr_q[15:0];

endmodule

`default_nettype wire

//--- source/reset_gen.sv
/* Core reset generator. Combines the board reset with the JTAG system reset and
   stretches the result, so even a short SRST pulse gives a full core reset. */
`timescale 1ns/1ps
`default_nettype none
`include "board_defines.svh"

module reset_gen (
  input  logic clk_i,
  input  logic reset_i,        // Board reset, sync, active high
  input  logic srst_n_i,       // JTAG system reset from the pad, async
  output logic core_reset_o    // Stretched, active high
);

  localparam int cnt_w = $clog2(`RST_STRETCH + 1);

  logic [1:0]       srst_sync_q;   // Two-flop synchronizer
  logic [cnt_w-1:0] cnt_q;         // Cycles of reset still to hold

  //////////////////////////////////////////////////
  // SRST synchronizer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      srst_sync_q <= 2'b11;   // Released, board reset covers it
    end else begin
      srst_sync_q <= {srst_sync_q[0], srst_n_i};
    end
  end

  //////////////////////////////////////////////////
  // Stretch counter
  //////////////////////////////////////////////////

  // Reloads while either source is active, counts down once both are released
  always_ff @(posedge clk_i) begin
    if (reset_i || !srst_sync_q[1]) begin
      cnt_q <= cnt_w'(`RST_STRETCH);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign core_reset_o = (cnt_q != '0);

endmodule

`default_nettype wire

//--- source/jtag_overlay_mux.sv
/* JTAG overlay. With the strap pad high the JTAG pads are handed to the TAP and
   the core sees tie-off values; with the strap low everything passes through. */
`timescale 1ns/1ps
`default_nettype none
`include "board_defines.svh"

module jtag_overlay_mux
  import board_pkg::*;
(
  // Padring side
  input  io_vec_t  in_padring_i,
  output io_vec_t  out_padring_o,
  output io_vec_t  oe_padring_o,
  // Core side
  output io_vec_t  in_core_o,
  input  io_vec_t  out_core_i,
  input  io_vec_t  oe_core_i,
  // JTAG pins toward TAP and reset generator
  output logic     jtag_tck_o,
  output logic     jtag_tms_o,
  output logic     jtag_tdi_o,
  output logic     jtag_trst_n_o,
  output logic     jtag_srst_n_o,
  input  logic     jtag_tdo_i
);

  // Pads owned by debug while the strap is high
  localparam io_vec_t jtag_mask = io_vec_t'((1 << `IDX_TCK) | (1 << `IDX_TMS) |
                                            (1 << `IDX_TDI) | (1 << `IDX_TDO) |
                                            (1 << `IDX_TRST) | (1 << `IDX_SRST));
  // TMS idles high on the core side
  localparam io_vec_t tie_off = io_vec_t'(1 << `IDX_TMS);

  logic jtag_en;

  assign jtag_en = in_padring_i[`IDX_JTAG_EN];   // Strap always passes through

  //////////////////////////////////////////////////
  // Pin routing
  //////////////////////////////////////////////////

  always_comb begin
    if (jtag_en) begin
      in_core_o                   = (in_padring_i & ~jtag_mask) | tie_off;
      out_padring_o               = out_core_i & ~jtag_mask;
      oe_padring_o                = oe_core_i & ~jtag_mask;
      out_padring_o[`IDX_TDO]     = jtag_tdo_i;   // TDO is the only driven pin
      oe_padring_o[`IDX_TDO]      = 1'b1;
      jtag_tck_o                  = in_padring_i[`IDX_TCK];
      jtag_tms_o                  = in_padring_i[`IDX_TMS];
      jtag_tdi_o                  = in_padring_i[`IDX_TDI];
      jtag_trst_n_o               = in_padring_i[`IDX_TRST];
      jtag_srst_n_o               = in_padring_i[`IDX_SRST];
    end else begin
      in_core_o     = in_padring_i;
      out_padring_o = out_core_i;
      oe_padring_o  = oe_core_i;
      // TAP parked in reset, system reset released
      jtag_tck_o    = 1'b0;
      jtag_tms_o    = 1'b1;
      jtag_tdi_o    = 1'b0;
      jtag_trst_n_o = 1'b0;
      jtag_srst_n_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/pad_ring.sv
/* Pad ring model. Masks unbonded pads and applies the MIO inversion attribute
   in both directions; purely combinational between pads and the core side. */
`timescale 1ns/1ps
`default_nettype none
`include "board_defines.svh"

module pad_ring
  import board_pkg::*;
(
  // Pad side
  input  mio_vec_t   mio_in_i,
  output mio_vec_t   mio_out_o,
  output mio_vec_t   mio_oe_o,
  input  dio_vec_t   dio_in_i,
  output dio_vec_t   dio_out_o,
  output dio_vec_t   dio_oe_o,
  // Core side
  output io_vec_t    core_in_o,
  input  io_vec_t    core_out_i,
  input  io_vec_t    core_oe_i,
  // Attributes, MIO only
  input  gpio_word_t mio_attr_i
);

  mio_vec_t mio_core_out;
  mio_vec_t mio_core_oe;
  dio_vec_t dio_core_out;
  dio_vec_t dio_core_oe;

  // Split combined core vector
  assign {dio_core_out, mio_core_out} = core_out_i;
  assign {dio_core_oe, mio_core_oe}   = core_oe_i;

  //////////////////////////////////////////////////
  // Inbound, pads toward core
  //////////////////////////////////////////////////

  // Unbonded pads read 0, inversion applied before masking
  assign core_in_o = {dio_in_i & `DIO_CONNECT,
                      (mio_in_i ^ mio_attr_i) & `MIO_CONNECT};

  //////////////////////////////////////////////////
  // Outbound, core toward pads
  //////////////////////////////////////////////////

  assign mio_out_o = (mio_core_out ^ mio_attr_i) & `MIO_CONNECT;
  assign mio_oe_o  = mio_core_oe & `MIO_CONNECT;   // Never drive unbonded
  assign dio_out_o = dio_core_out & `DIO_CONNECT;
  assign dio_oe_o  = dio_core_oe & `DIO_CONNECT;

endmodule

`default_nettype wire

//--- source/board_pkg.sv
/* Shared types for the board wrapper: pad vectors, register words and the
   JTAG TAP state and instruction encodings. */
`default_nettype none
`include "board_defines.svh"

package board_pkg;

  typedef logic [`NUM_MIO-1:0]  mio_vec_t;   // One bit per MIO
  typedef logic [`NUM_DIO-1:0]  dio_vec_t;   // One bit per DIO
  typedef logic [`NUM_IO-1:0]   io_vec_t;    // Combined, MIO in low bits
  typedef logic [7:0]           gpio_word_t;
  typedef logic [3:0]           led_word_t;
  typedef logic [`IR_WIDTH-1:0] ir_t;

  // Standard 16-state TAP controller
  typedef enum logic [3:0] {
    TEST_LOGIC_RESET, RUN_TEST_IDLE,
    SELECT_DR_SCAN, CAPTURE_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPDATE_DR,
    SELECT_IR_SCAN, CAPTURE_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
  } tap_state_t;

  typedef enum logic [`IR_WIDTH-1:0] {
    IR_IDCODE = 2'b00,
    IR_GPIO   = 2'b01,
    IR_AUX    = 2'b10,
    IR_BYPASS = 2'b11
  } ir_code_t;

endpackage

`default_nettype wire

//--- source/board_defines.svh
/* Board-level constants for pad counts, JTAG pin placement and reset timing.
   Included by the package and by any block that needs a pad index or mask. */
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

`define NUM_MIO      8                 // Muxed pads
`define NUM_DIO      6                 // Dedicated pads
`define NUM_IO       14                // MIO in low bits, DIO above
`define MIO_CONNECT  8'hFF             // All MIO bonded
`define DIO_CONNECT  6'h1F             // DIO 5 not bonded
`define IDX_JTAG_EN  6                 // Strap, MIO 6
`define IDX_SRST     7                 // System reset, active low, MIO 7
`define IDX_TCK      8                 // DIO 0
`define IDX_TMS      9                 // DIO 1
`define IDX_TDI      10                // DIO 2
`define IDX_TDO      11                // DIO 3
`define IDX_TRST     12                // DIO 4
`define JTAG_IDCODE  32'h1B0C_4A73
`define RST_STRETCH  4                 // Core reset length in clk cycles
`define IR_WIDTH     2
`endif
